// ==== hw/iccm_pkg.sv ====
// ICCM geometry, write size encoding and SECDED check-bit function, referenced by package scope
`default_nettype none

package iccm_pkg;

   // ****************************************
   // Geometry
   // ****************************************
   localparam int ICCM_BITS          = 12;              // Byte address width, 4 KB
   localparam int ICCM_NUM_BANKS     = 4;
   localparam int ICCM_BANK_HI       = 3;               // Bank index is addr[3:2]
   localparam int ICCM_BANK_INDEX_LO = 4;               // Row index starts here
   localparam int ICCM_ROWS          = 256;
   localparam int ICCM_ECC_WIDTH     = 7;
   localparam int ICCM_WORD_WIDTH    = 32 + ICCM_ECC_WIDTH;

   // Write size, dword spans two banks
   typedef enum logic [1:0] {
      SIZE_WORD  = 2'b10,
      SIZE_DWORD = 2'b11
   } access_size_e;

   // Hamming code over positions 1..38, check bits at the powers of two
   // Bit 6 is overall parity over data and Hamming bits
   function automatic logic [ICCM_ECC_WIDTH-1:0] ecc_encode(input logic [31:0] data);
      logic [ICCM_ECC_WIDTH-1:0] ecc;
      int d;
      ecc = '0;
      d   = 0;
      for (int pos = 1; pos < 39; pos++) begin
         if ((pos & (pos - 1)) != 0) begin          // Data position
            for (int k = 0; k < 6; k++) begin
               if (pos[k])
                  ecc[k] = ecc[k] ^ data[d];
            end
            d++;
         end
      end
      ecc[6] = ^{data, ecc[5:0]};
      return ecc;
   endfunction

endpackage

`default_nettype wire

// ==== hw/iccm_request_stage.sv ====
// ICCM request stage: bank decode, row steering, write encoding and read address registers
`timescale 1ns/1ns
`default_nettype none

module iccm_request_stage (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   wren,
   input  wire logic                                   rden,
   input  wire logic [iccm_pkg::ICCM_BITS-1:1]         rw_addr,      // Halfword address
   input  iccm_pkg::access_size_e                      wr_size,
   input  wire logic [63:0]                            wr_data,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]         bank_wren,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]         bank_rden,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] bank_row,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                [iccm_pkg::ICCM_WORD_WIDTH-1:0]        bank_wr_word,
   output logic [iccm_pkg::ICCM_BITS-1:1]              inc_addr,
   output logic [iccm_pkg::ICCM_BANK_HI:2]             rd_lo_bank_q,
   output logic [iccm_pkg::ICCM_BANK_HI:2]             rd_hi_bank_q,
   output logic                                        rd_half_q,
   output logic                                        rd_pending    // rden delayed one cycle
);

   logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] lo_word;
   logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] hi_word;
   logic                                 dword;

   // Next word, two halfwords on
   assign inc_addr = rw_addr + (iccm_pkg::ICCM_BITS-1)'(2);
   assign dword    = (wr_size == iccm_pkg::SIZE_DWORD);

   // Check bits generated per 32-bit half
   assign lo_word = {iccm_pkg::ecc_encode(wr_data[31:0]), wr_data[31:0]};
   assign hi_word = {iccm_pkg::ecc_encode(wr_data[63:32]), wr_data[63:32]};

   for (genvar i = 0; i < iccm_pkg::ICCM_NUM_BANKS; i++) begin : g_bank
      logic is_lo;
      logic is_hi;
      assign is_lo = (rw_addr[iccm_pkg::ICCM_BANK_HI:2] == 2'(i));
      assign is_hi = (inc_addr[iccm_pkg::ICCM_BANK_HI:2] == 2'(i));

      assign bank_wren[i] = wren & (is_lo | (dword & is_hi));   // Word write hits one bank
      assign bank_rden[i] = rden & (is_lo | is_hi);
      // Second word of the pair may sit one row further on
      assign bank_row[i]  = is_hi ? inc_addr[iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO]
                                  : rw_addr[iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO];
      assign bank_wr_word[i] = is_lo ? lo_word : hi_word;
   end

   // ****************************************
   // Read address pipeline
   // ****************************************
   always_ff @(posedge clk) begin
      rd_lo_bank_q <= rw_addr[iccm_pkg::ICCM_BANK_HI:2];
      rd_hi_bank_q <= inc_addr[iccm_pkg::ICCM_BANK_HI:2];
      rd_half_q    <= rw_addr[1];                      // Odd halfword start
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= rden;
      end
   end

endmodule

`default_nettype wire

// ==== hw/iccm_bank_array.sv ====
// ICCM storage: four single-port banks with registered read and a persistent-fault register each
`timescale 1ns/1ns
`default_nettype none

module iccm_bank_array (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]    bank_wren,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]    bank_rden,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                     [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] bank_row,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                     [iccm_pkg::ICCM_WORD_WIDTH-1:0]   bank_wr_word,
   input  wire logic                                   fault_wr,
   input  wire logic [iccm_pkg::ICCM_BANK_HI:2]        fault_bank,
   input  wire logic [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] fault_row,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   fault_mask,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                [iccm_pkg::ICCM_WORD_WIDTH-1:0]        bank_dout
);

   for (genvar i = 0; i < iccm_pkg::ICCM_NUM_BANKS; i++) begin : g_bank
      logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] mem [iccm_pkg::ICCM_ROWS];
      logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] dout_q;
      logic [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] row_q;     // Row last read
      logic [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] flt_row;
      logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] flt_mask;
      logic                                 flt_valid;

      always_ff @(posedge clk) begin
         if (bank_wren[i])
            mem[bank_row[i]] <= bank_wr_word[i];       // Writes store clean data
         if (bank_rden[i]) begin
            dout_q <= mem[bank_row[i]];
            row_q  <= bank_row[i];
         end
      end

      // Hard fault model
      always_ff @(posedge clk) begin
         if (reset) begin
            flt_valid <= 1'b0;
            flt_row   <= '0;
            flt_mask  <= '0;
         end else if (fault_wr && fault_bank == 2'(i)) begin
            flt_valid <= 1'b1;
            flt_row   <= fault_row;
            flt_mask  <= fault_mask;
         end
      end

      assign bank_dout[i] = dout_q ^ ((flt_valid && row_q == flt_row) ? flt_mask : '0);
   end

endmodule

`default_nettype wire

// ==== hw/iccm_redundancy.sv ====
// ICCM redundant rows: correction load, write shadowing, LRU replacement and read substitution selects
`timescale 1ns/1ns
`default_nettype none

module iccm_redundancy (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   wren,
   input  wire logic                                   rden,
   input  wire logic [iccm_pkg::ICCM_BITS-1:1]         rw_addr,
   input  wire logic [iccm_pkg::ICCM_BITS-1:1]         inc_addr,
   input  iccm_pkg::access_size_e                      wr_size,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                     [iccm_pkg::ICCM_WORD_WIDTH-1:0]   bank_wr_word,
   input  wire logic                                   buf_correct_ecc,
   input  wire logic                                   correction_state,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]         sel_row0_q,
   output logic [iccm_pkg::ICCM_NUM_BANKS-1:0]         sel_row1_q,
   output logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]        row0_data,
   output logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]        row1_data
);

   logic [1:0][iccm_pkg::ICCM_BITS-1:2]          row_addr;      // Word address per row
   logic [1:0][iccm_pkg::ICCM_WORD_WIDTH-1:0]    row_data;
   logic [1:0]                                   row_valid;
   logic [1:0]                                   hit_lo, hit_hi;
   logic [1:0]                                   load, data_en;
   logic [1:0][iccm_pkg::ICCM_NUM_BANKS-1:0]     sel;
   logic                                         lru;           // Row to replace next
   logic                                         dword;

   assign dword = (wr_size == iccm_pkg::SIZE_DWORD);

   // ****************************************
   // Address match
   // ****************************************
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         hit_lo[r]  = row_valid[r] & (rw_addr[iccm_pkg::ICCM_BITS-1:2] == row_addr[r]);
         hit_hi[r]  = row_valid[r] & (inc_addr[iccm_pkg::ICCM_BITS-1:2] == row_addr[r]);
         load[r]    = buf_correct_ecc & (lru == r[0]);
         // Shadow writes, second word counts only for dword
         data_en[r] = load[r] | (wren & (hit_lo[r] | (dword & hit_hi[r])));
         for (int i = 0; i < iccm_pkg::ICCM_NUM_BANKS; i++) begin
            sel[r][i] = (hit_lo[r] & (rw_addr[iccm_pkg::ICCM_BANK_HI:2] == 2'(i))) |
                        (hit_hi[r] & (inc_addr[iccm_pkg::ICCM_BANK_HI:2] == 2'(i)));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         row_valid  <= '0;
         lru        <= 1'b0;
         sel_row0_q <= '0;
         sel_row1_q <= '0;
      end else begin
         sel_row0_q <= sel[0];                        // Lines up with bank dout
         sel_row1_q <= sel[1];
         for (int r = 0; r < 2; r++) begin
            if (load[r])
               row_valid[r] <= 1'b1;
         end
         if (buf_correct_ecc)
            lru <= ~lru;
         else if (rden && correction_state && (|(hit_lo | hit_hi)))
            lru <= hit_lo[0] | hit_hi[0];             // Steer away from the row hit
      end
   end

   // Row payload
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (load[r])
            row_addr[r] <= rw_addr[iccm_pkg::ICCM_BITS-1:2];
         if (data_en[r])
            row_data[r] <= load[r] ? bank_wr_word[rw_addr[iccm_pkg::ICCM_BANK_HI:2]]
                                   : bank_wr_word[row_addr[r][iccm_pkg::ICCM_BANK_HI:2]];
      end
   end

   assign row0_data = row_data[0];
   assign row1_data = row_data[1];

endmodule

`default_nettype wire

// ==== hw/iccm_read_select.sv ====
// ICCM read select: redundant row substitution per bank, then low and high word pick
`timescale 1ns/1ns
`default_nettype none

module iccm_read_select (
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
                     [iccm_pkg::ICCM_WORD_WIDTH-1:0]   bank_dout,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]    sel_row0_q,
   input  wire logic [iccm_pkg::ICCM_NUM_BANKS-1:0]    sel_row1_q,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   row0_data,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   row1_data,
   input  wire logic [iccm_pkg::ICCM_BANK_HI:2]        rd_lo_bank_q,
   input  wire logic [iccm_pkg::ICCM_BANK_HI:2]        rd_hi_bank_q,
   output logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]        lo_word,
   output logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]        hi_word
);

   logic [iccm_pkg::ICCM_NUM_BANKS-1:0][iccm_pkg::ICCM_WORD_WIDTH-1:0] bank_fn;

   // Row 1 wins if both match
   for (genvar i = 0; i < iccm_pkg::ICCM_NUM_BANKS; i++) begin : g_sub
      assign bank_fn[i] = sel_row1_q[i] ? row1_data :
                          sel_row0_q[i] ? row0_data : bank_dout[i];
   end

   assign lo_word = bank_fn[rd_lo_bank_q];            // Addressed word
   assign hi_word = bank_fn[rd_hi_bank_q];            // Following word

endmodule

`default_nettype wire

// ==== hw/iccm_ecc_check.sv ====
// ICCM ECC check: SECDED correction of both read words, halfword alignment and output register
`timescale 1ns/1ns
`default_nettype none

module iccm_ecc_check (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   rd_pending,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   lo_word,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   hi_word,
   input  wire logic                                   rd_half_q,
   output logic [63:0]                                 rd_data,
   output logic                                        rd_valid,
   output logic                                        single_err,
   output logic                                        double_err
);

   logic [33:0] lo_chk, hi_chk;       // {double, single, data}
   logic [63:0] joined;

   // Syndrome names the Hamming position of a single flip
   function automatic logic [33:0] check_word(input logic [iccm_pkg::ICCM_WORD_WIDTH-1:0] w);
      logic [iccm_pkg::ICCM_ECC_WIDTH-1:0] recalc;
      logic [5:0]                          syn;
      logic                                par_err;
      logic [31:0]                         data;
      int                                  d;
      recalc  = iccm_pkg::ecc_encode(w[31:0]);
      syn     = w[37:32] ^ recalc[5:0];
      par_err = ^w;                                  // Odd flips
      data    = w[31:0];
      d       = 0;
      for (int pos = 1; pos < 39; pos++) begin
         if ((pos & (pos - 1)) != 0) begin
            if (par_err && syn == pos[5:0])
               data[d] = ~data[d];
            d++;
         end
      end
      return {~par_err & (syn != '0), par_err, data};
   endfunction

   assign lo_chk = check_word(lo_word);
   assign hi_chk = check_word(hi_word);
   assign joined = {hi_chk[31:0], lo_chk[31:0]};

   // ****************************************
   // Output register
   // ****************************************
   always_ff @(posedge clk) begin
      rd_data <= rd_half_q ? {16'b0, joined[63:16]} : joined;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid   <= 1'b0;
         single_err <= 1'b0;
         double_err <= 1'b0;
      end else begin
         rd_valid   <= rd_pending;
         double_err <= rd_pending & (lo_chk[33] | hi_chk[33]);
         single_err <= rd_pending & (lo_chk[32] | hi_chk[32]) & ~(lo_chk[33] | hi_chk[33]);
      end
   end

endmodule

`default_nettype wire

// ==== hw/iccm_top.sv ====
// ICCM top level: request, bank array, read select and ECC check pipeline with redundant rows
`timescale 1ns/1ns
`default_nettype none

module iccm_top (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   wren,
   input  wire logic                                   rden,
   input  wire logic [iccm_pkg::ICCM_BITS-1:1]         rw_addr,
   input  iccm_pkg::access_size_e                      wr_size,
   input  wire logic [63:0]                            wr_data,
   input  wire logic                                   buf_correct_ecc,   // Correction write
   input  wire logic                                   correction_state,
   input  wire logic                                   fault_wr,
   input  wire logic [iccm_pkg::ICCM_BANK_HI:2]        fault_bank,
   input  wire logic [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] fault_row,
   input  wire logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]   fault_mask,
   output logic [63:0]                                 rd_data,
   output logic                                        rd_valid,
   output logic                                        single_err,
   output logic                                        double_err
);

   logic [iccm_pkg::ICCM_NUM_BANKS-1:0]   bank_wren, bank_rden;
   logic [iccm_pkg::ICCM_NUM_BANKS-1:0]
         [iccm_pkg::ICCM_BITS-1:iccm_pkg::ICCM_BANK_INDEX_LO] bank_row;
   logic [iccm_pkg::ICCM_NUM_BANKS-1:0][iccm_pkg::ICCM_WORD_WIDTH-1:0] bank_wr_word;
   logic [iccm_pkg::ICCM_NUM_BANKS-1:0][iccm_pkg::ICCM_WORD_WIDTH-1:0] bank_dout;
   logic [iccm_pkg::ICCM_BITS-1:1]        inc_addr;
   logic [iccm_pkg::ICCM_BANK_HI:2]       rd_lo_bank_q, rd_hi_bank_q;
   logic                                  rd_half_q, rd_pending;
   logic [iccm_pkg::ICCM_NUM_BANKS-1:0]   sel_row0_q, sel_row1_q;
   logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]  row0_data, row1_data;
   logic [iccm_pkg::ICCM_WORD_WIDTH-1:0]  lo_word, hi_word;

   iccm_request_stage u_req (
      .clk, .reset, .wren, .rden, .rw_addr, .wr_size, .wr_data,
      .bank_wren, .bank_rden, .bank_row, .bank_wr_word, .inc_addr,
      .rd_lo_bank_q, .rd_hi_bank_q, .rd_half_q, .rd_pending
   );

   iccm_bank_array u_banks (
      .clk, .reset, .bank_wren, .bank_rden, .bank_row, .bank_wr_word,
      .fault_wr, .fault_bank, .fault_row, .fault_mask, .bank_dout
   );

   iccm_redundancy u_red (
      .clk, .reset, .wren, .rden, .rw_addr, .inc_addr, .wr_size, .bank_wr_word,
      .buf_correct_ecc, .correction_state,
      .sel_row0_q, .sel_row1_q, .row0_data, .row1_data
   );

   iccm_read_select u_rsel (
      .bank_dout, .sel_row0_q, .sel_row1_q, .row0_data, .row1_data,
      .rd_lo_bank_q, .rd_hi_bank_q, .lo_word, .hi_word
   );

   iccm_ecc_check u_ecc (
      .clk, .reset, .rd_pending, .lo_word, .hi_word, .rd_half_q,
      .rd_data, .rd_valid, .single_err, .double_err
   );

endmodule

`default_nettype wire

// ==== verification/iccm_top_chk.sv ====
// ICCM protocol checks on read latency and error flags, bound into iccm_top
`timescale 1ns/1ns
`default_nettype none

module iccm_top_chk (
   input wire logic clk,
   input wire logic reset,
   input wire logic wren,
   input wire logic rden,
   input wire logic rd_valid,
   input wire logic single_err,
   input wire logic double_err
);

   int fail_count = 0;                                // Failure tally, read from the top

   a_rd_latency: assert property (@(posedge clk) disable iff (reset) rden |-> ##2 rd_valid)
      else begin
         fail_count++;
         $error("rd_valid missing two cycles after rden");
      end
   a_no_stray_valid: assert property (@(posedge clk) disable iff (reset)
                                      rd_valid |-> $past(rden, 2))
      else begin
         fail_count++;
         $error("rd_valid without a read two cycles earlier");
      end
   a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
                                       !(single_err && double_err))
      else begin
         fail_count++;
         $error("single_err and double_err high together");
      end
   a_flags_with_valid: assert property (@(posedge clk) disable iff (reset)
                                        (single_err || double_err) |-> rd_valid)
      else begin
         fail_count++;
         $error("Error flag raised without rd_valid");
      end
   a_one_request: assert property (@(posedge clk) disable iff (reset) !(wren && rden))
      else begin
         fail_count++;
         $error("wren and rden high in the same cycle");
      end

endmodule

bind iccm_top iccm_top_chk chk0 (
   .clk(clk), .reset(reset), .wren(wren), .rden(rden),
   .rd_valid(rd_valid), .single_err(single_err), .double_err(double_err)
);

`default_nettype wire

// ==== verification/iccm_tb.sv ====
// ICCM testbench: fill, random and directed ECC and redundancy traffic against a reference model
`timescale 1ns/1ns
`default_nettype none

module iccm_tb;

   localparam int WORDS        = iccm_pkg::ICCM_NUM_BANKS * iccm_pkg::ICCM_ROWS;
   localparam int INIT_OPS     = WORDS / 2;           // Dword fill of every word
   localparam int RAND_OPS     = 300;
   localparam int DIRECTED_OPS = 150;
   localparam int TIMEOUT_NS   = (INIT_OPS + RAND_OPS + DIRECTED_OPS) * 40 + 2000;

   typedef struct packed {
      logic [63:0] data;
      logic        single;
      logic        dbl;
      logic [31:0] edge_n;                            // Last edge before rden is driven
   } exp_t;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic wren = 1'b0;
   logic rden = 1'b0;
   logic [10:0] rw_addr = '0;                         // Halfword address
   iccm_pkg::access_size_e wr_size = iccm_pkg::SIZE_WORD;
   logic [63:0] wr_data = '0;
   logic buf_correct_ecc = 1'b0;
   logic correction_state = 1'b0;
   logic fault_wr = 1'b0;
   logic [1:0] fault_bank = '0;
   logic [7:0] fault_row = '0;
   logic [38:0] fault_mask = '0;
   logic [63:0] rd_data;
   logic rd_valid, single_err, double_err;

   // ****************************************
   // Reference model state
   // ****************************************
   logic [31:0] ref_mem [WORDS];
   logic [3:0]  flt_valid = '0;
   logic [7:0]  flt_row [4];
   logic [38:0] flt_mask [4];
   logic [9:0]  red_addr [2];                         // Word address per redundant row
   logic [1:0]  red_valid = '0;
   logic        lru = 1'b0;
   exp_t        exp_q [$];
   int cyc = 0;
   int reads_checked = 0;
   int mismatches = 0;
   int other_errs = 0;

   iccm_top dut0 (.*);

   initial begin
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;              // Edge count for latency

   function automatic logic covers(input int r, input logic [9:0] wa);
      return red_valid[r] && red_addr[r] == wa;
   endfunction

   // {double, single, data} for one stored word
   function automatic logic [33:0] word_check(input logic [9:0] wa);
      logic [1:0] bank;
      int flips;
      bank  = wa[1:0];
      flips = 0;
      if (!covers(0, wa) && !covers(1, wa) && flt_valid[bank] && flt_row[bank] == wa[9:2])
         flips = $countones(flt_mask[bank]);
      if (flips >= 2)
         return {1'b1, 1'b0, ref_mem[wa] ^ flt_mask[bank][31:0]};   // Detected, left as read
      return {1'b0, flips == 1, ref_mem[wa]};
   endfunction

   function automatic exp_t expected_read(input logic [10:0] a);
      logic [33:0] lo;
      logic [33:0] hi;
      logic [63:0] d;
      exp_t e;
      lo       = word_check(a[10:1]);
      hi       = word_check(a[10:1] + 10'd1);         // Next word, wraps at the top
      d        = {hi[31:0], lo[31:0]};
      e.data   = a[0] ? {16'h0, d[63:16]} : d;
      e.dbl    = lo[33] | hi[33];
      e.single = (lo[32] | hi[32]) & ~e.dbl;
      e.edge_n = '0;
      return e;
   endfunction

   // ****************************************
   // Stimulus tasks
   // ****************************************
   task automatic next_cycle();
      @(posedge clk);
      #2;
      wren            = 1'b0;
      rden            = 1'b0;
      buf_correct_ecc = 1'b0;
      fault_wr        = 1'b0;
   endtask

   task automatic write_word(input logic [9:0] wa, input logic [31:0] d, input logic correct);
      next_cycle();
      wren            = 1'b1;
      rw_addr         = {wa, 1'b0};
      wr_size         = iccm_pkg::SIZE_WORD;
      wr_data         = {$urandom, d};                // Upper half is ignored
      buf_correct_ecc = correct;
      ref_mem[wa]     = d;
      if (correct) begin                              // LRU row takes the word
         red_addr[lru]  = wa;
         red_valid[lru] = 1'b1;
         lru            = ~lru;
      end
   endtask

   task automatic write_dword(input logic [9:0] wa, input logic [63:0] d);
      logic [9:0] wb;
      wb = wa + 10'd1;
      next_cycle();
      wren        = 1'b1;
      rw_addr     = {wa, 1'b0};
      wr_size     = iccm_pkg::SIZE_DWORD;
      wr_data     = d;
      ref_mem[wa] = d[31:0];
      ref_mem[wb] = d[63:32];
   endtask

   task automatic read_at(input logic [10:0] a, input logic cs);
      exp_t e;
      logic [9:0] wa;
      logic [9:0] wb;
      wa = a[10:1];
      wb = wa + 10'd1;
      next_cycle();
      rden             = 1'b1;
      rw_addr          = a;
      correction_state = cs;
      e                = expected_read(a);
      e.edge_n         = cyc;
      exp_q.push_back(e);
      if (cs && (covers(0, wa) || covers(0, wb) || covers(1, wa) || covers(1, wb)))
         lru = covers(0, wa) || covers(0, wb);       // Away from the row hit
   endtask

   task automatic load_fault(input logic [1:0] bank, input logic [7:0] row,
                             input logic [38:0] mask);
      next_cycle();
      fault_wr        = 1'b1;
      fault_bank      = bank;
      fault_row       = row;
      fault_mask      = mask;
      flt_valid[bank] = 1'b1;
      flt_row[bank]   = row;
      flt_mask[bank]  = mask;
   endtask

   task automatic drain();
      next_cycle();
      while (exp_q.size() != 0)
         next_cycle();
   endtask

   // ****************************************
   // Result comparison
   // ****************************************
   always @(negedge clk) begin : compare_results
      exp_t e;
      if (rd_valid) begin
         assert (exp_q.size() != 0) else begin
            other_errs++;
            $display("Unexpected rd_valid at %0t ns with no read outstanding", $time);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            reads_checked++;
            assert (cyc == e.edge_n + 2) else begin
               other_errs++;
               $display("Wrong read latency at %0t ns: read from edge %0d returned at edge %0d",
                        $time, e.edge_n, cyc);
            end
            assert (rd_data === e.data) else begin
               mismatches++;
               $display("Mismatch at %0t ns: rd_data expected %h got %h",
                        $time, e.data, rd_data);
            end
            assert (single_err === e.single) else begin
               mismatches++;
               $display("Mismatch at %0t ns: single_err expected %b got %b",
                        $time, e.single, single_err);
            end
            assert (double_err === e.dbl) else begin
               mismatches++;
               $display("Mismatch at %0t ns: double_err expected %b got %b",
                        $time, e.dbl, double_err);
            end
         end
      end else if (exp_q.size() != 0) begin
         assert (cyc <= exp_q[0].edge_n + 2) else begin
            other_errs++;
            $display("No rd_valid by %0t ns for the read from edge %0d", $time, exp_q[0].edge_n);
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the run did not finish", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

   // ****************************************
   // Test sequence
   // ****************************************
   initial begin : run_tests
      void'($urandom(19773));
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;
      for (int i = 0; i < INIT_OPS; i++)
         write_dword(10'(2 * i), {$urandom, $urandom});
      // Mixed traffic, even and odd halfword reads
      for (int i = 0; i < RAND_OPS; i++) begin
         if ($urandom_range(2) != 0)
            read_at(11'($urandom), 1'b0);
         else if ($urandom_range(1) != 0)
            write_dword(10'($urandom), {$urandom, $urandom});
         else
            write_word(10'($urandom), $urandom, 1'b0);
      end
      read_at({10'h0F3, 1'b0}, 1'b0);                 // Bank 3 into bank 0
      read_at({10'h3FF, 1'b0}, 1'b0);                 // Top of memory wraps
      read_at({10'h3FF, 1'b1}, 1'b0);
      for (int i = 0; i < 16; i++)
         read_at(11'(11'h100 + i), 1'b0);             // Back to back
      drain();
      // Single then double fault on word 0x041
      load_fault(2'd1, 8'h10, 39'h00_0000_0080);
      read_at({10'h041, 1'b0}, 1'b0);
      read_at({10'h040, 1'b1}, 1'b0);
      load_fault(2'd1, 8'h10, 39'h40_0000_0000);      // Overall parity bit
      read_at({10'h040, 1'b0}, 1'b0);
      load_fault(2'd1, 8'h10, 39'h00_0001_0004);
      read_at({10'h041, 1'b0}, 1'b0);
      drain();
      // Correction write, then shadowed writes
      write_word(10'h041, $urandom, 1'b1);
      read_at({10'h041, 1'b0}, 1'b0);
      read_at({10'h040, 1'b1}, 1'b0);
      drain();
      write_word(10'h041, $urandom, 1'b0);
      read_at({10'h041, 1'b0}, 1'b0);
      drain();
      write_dword(10'h040, {$urandom, $urandom});
      read_at({10'h040, 1'b0}, 1'b0);
      drain();
      // Three corrections, third evicts first
      load_fault(2'd0, 8'h20, 39'h00_0000_0011);
      load_fault(2'd2, 8'h28, 39'h00_8000_0001);
      load_fault(2'd3, 8'h30, 39'h01_0000_0100);
      write_word(10'h080, $urandom, 1'b1);
      write_word(10'h0A2, $urandom, 1'b1);
      write_word(10'h0C3, $urandom, 1'b1);
      read_at({10'h080, 1'b0}, 1'b0);
      read_at({10'h0A2, 1'b0}, 1'b0);
      read_at({10'h0C3, 1'b0}, 1'b0);
      read_at({10'h041, 1'b0}, 1'b0);
      drain();
      // Hit under correction_state protects its row
      read_at({10'h0A2, 1'b0}, 1'b1);
      drain();
      write_word(10'h080, $urandom, 1'b1);
      read_at({10'h0A2, 1'b0}, 1'b0);
      read_at({10'h080, 1'b0}, 1'b0);
      read_at({10'h0C3, 1'b0}, 1'b0);
      drain();
      other_errs += dut0.chk0.fail_count;
      $display("Reads checked %0d, mismatches %0d, other errors %0d",
               reads_checked, mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== iccm_top.f ====
hw/iccm_pkg.sv
hw/iccm_request_stage.sv
hw/iccm_bank_array.sv
hw/iccm_redundancy.sv
hw/iccm_read_select.sv
hw/iccm_ecc_check.sv
hw/iccm_top.sv
verification/iccm_top_chk.sv
verification/iccm_tb.sv
